// File: rtl/pw_pkg.sv
package pw_pkg;

   ////////////////////
   // sizes
   ////////////////////
   localparam int PATTERN_BYTES = 8;  // bytes compared by the matcher
   localparam int DELAY_W       = 20;
   localparam int WIDTH_W       = 17;

   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   typedef logic [3:0] pat_count_t;  // 0 .. PATTERN_BYTES

   // byte 0 sits in the lowest lane
   typedef logic [PATTERN_BYTES-1:0][7:0] pattern_t;

   typedef logic [DELAY_W-1:0] trig_delay_t;
   typedef logic [WIDTH_W-1:0] trig_width_t;

   typedef enum logic [1:0] {
      SPEED_AUTO = 2'd0,
      SPEED_LS   = 2'd1,
      SPEED_FS   = 2'd2,
      SPEED_HS   = 2'd3
   } usb_speed_t;

   ////////////////////
   // register map
   ////////////////////
   localparam reg_addr_t ADDR_ARM       = 8'h00;  // wr bit0 arms, rd {busy, armed}
   localparam reg_addr_t ADDR_SPEED     = 8'h01;
   localparam reg_addr_t ADDR_PAT_BYTES = 8'h02;
   localparam reg_addr_t ADDR_DELAY0    = 8'h03;  // lsb first, 3 bytes
   localparam reg_addr_t ADDR_DELAY1    = 8'h04;
   localparam reg_addr_t ADDR_DELAY2    = 8'h05;
   localparam reg_addr_t ADDR_WIDTH0    = 8'h06;  // lsb first, 3 bytes
   localparam reg_addr_t ADDR_WIDTH1    = 8'h07;
   localparam reg_addr_t ADDR_WIDTH2    = 8'h08;
   localparam reg_addr_t ADDR_PATTERN0  = 8'h10;  // one byte per pattern lane
   localparam reg_addr_t ADDR_MASK0     = 8'h18;  // one byte per mask lane

endpackage

// File: rtl/pw_reg_file.sv
`timescale 1ns/1ps

module pw_reg_file (
   input  logic               fe_clk,
   input  logic               rst_n_i,
   input  pw_pkg::reg_addr_t  reg_addr_i,
   input  pw_pkg::reg_data_t  reg_wdata_i,
   input  logic               reg_wr_i,
   input  logic               reg_rd_i,
   output pw_pkg::reg_data_t  reg_rdata_o,
   input  logic               match_i,
   input  logic               trig_busy_i,
   output logic               armed_o,
   output pw_pkg::usb_speed_t speed_o,
   output pw_pkg::pat_count_t pat_bytes_o,
   output pw_pkg::pattern_t   pattern_o,
   output pw_pkg::pattern_t   mask_o,
   output pw_pkg::trig_delay_t delay_o,
   output pw_pkg::trig_width_t width_o
);

   pw_pkg::reg_addr_t pat_off;   // offset into pattern lanes
   pw_pkg::reg_addr_t mask_off;  // offset into mask lanes
   logic              pat_hit;
   logic              mask_hit;
   pw_pkg::reg_data_t rd_mux;

   assign pat_off  = reg_addr_i - pw_pkg::ADDR_PATTERN0;
   assign mask_off = reg_addr_i - pw_pkg::ADDR_MASK0;
   assign pat_hit  = (reg_addr_i >= pw_pkg::ADDR_PATTERN0) && (pat_off < pw_pkg::PATTERN_BYTES);
   assign mask_hit = (reg_addr_i >= pw_pkg::ADDR_MASK0) && (mask_off < pw_pkg::PATTERN_BYTES);

   ////////////////////
   // write side
   ////////////////////
   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         armed_o     <= 1'b0;
         speed_o     <= pw_pkg::SPEED_AUTO;
         pat_bytes_o <= '0;
         delay_o     <= '0;
         width_o     <= '0;
      end else begin
         // a match disarms, even against a write in the same cycle
         if (match_i) begin
            armed_o <= 1'b0;
         end else if (reg_wr_i && reg_addr_i == pw_pkg::ADDR_ARM && reg_wdata_i[0]) begin
            armed_o <= 1'b1;
         end
         if (reg_wr_i) begin
            case (reg_addr_i)
               pw_pkg::ADDR_SPEED:     speed_o <= pw_pkg::usb_speed_t'(reg_wdata_i[1:0]);
               pw_pkg::ADDR_PAT_BYTES: begin
                  if (reg_wdata_i > pw_pkg::PATTERN_BYTES)
                     pat_bytes_o <= pw_pkg::pat_count_t'(pw_pkg::PATTERN_BYTES);  // clamp
                  else
                     pat_bytes_o <= reg_wdata_i[3:0];
               end
               pw_pkg::ADDR_DELAY0:    delay_o[7:0]  <= reg_wdata_i;
               pw_pkg::ADDR_DELAY1:    delay_o[15:8] <= reg_wdata_i;
               pw_pkg::ADDR_DELAY2:    delay_o[pw_pkg::DELAY_W-1:16] <=
                                          reg_wdata_i[pw_pkg::DELAY_W-17:0];
               pw_pkg::ADDR_WIDTH0:    width_o[7:0]  <= reg_wdata_i;
               pw_pkg::ADDR_WIDTH1:    width_o[15:8] <= reg_wdata_i;
               pw_pkg::ADDR_WIDTH2:    width_o[pw_pkg::WIDTH_W-1:16] <=
                                          reg_wdata_i[pw_pkg::WIDTH_W-17:0];
               default: ;
            endcase
         end
      end
   end

   // pattern and mask lanes, plain storage
   always_ff @(posedge fe_clk) begin
      if (reg_wr_i && pat_hit)
         pattern_o[pat_off] <= reg_wdata_i;
      if (reg_wr_i && mask_hit)
         mask_o[mask_off] <= reg_wdata_i;
   end

   ////////////////////
   // read side
   ////////////////////
   always_comb begin
      rd_mux = '0;  // unmapped reads as zero
      case (reg_addr_i)
         pw_pkg::ADDR_ARM:       rd_mux = {6'b0, trig_busy_i, armed_o};
         pw_pkg::ADDR_SPEED:     rd_mux = {6'b0, speed_o};
         pw_pkg::ADDR_PAT_BYTES: rd_mux = {4'b0, pat_bytes_o};
         pw_pkg::ADDR_DELAY0:    rd_mux = delay_o[7:0];
         pw_pkg::ADDR_DELAY1:    rd_mux = delay_o[15:8];
         pw_pkg::ADDR_DELAY2:    rd_mux = pw_pkg::reg_data_t'(delay_o[pw_pkg::DELAY_W-1:16]);
         pw_pkg::ADDR_WIDTH0:    rd_mux = width_o[7:0];
         pw_pkg::ADDR_WIDTH1:    rd_mux = width_o[15:8];
         pw_pkg::ADDR_WIDTH2:    rd_mux = pw_pkg::reg_data_t'(width_o[pw_pkg::WIDTH_W-1:16]);
         default: begin
            if (pat_hit)
               rd_mux = pattern_o[pat_off];
            else if (mask_hit)
               rd_mux = mask_o[mask_off];
         end
      endcase
   end

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i)
         reg_rdata_o <= '0;
      else if (reg_rd_i)
         reg_rdata_o <= rd_mux;  // held until the next read
   end

endmodule

// File: rtl/rx_byte_window.sv
`timescale 1ns/1ps

module rx_byte_window (
   input  logic               fe_clk,
   input  logic               rst_n_i,
   input  pw_pkg::reg_data_t  fe_data_i,
   input  logic               fe_rxvalid_i,
   input  logic               fe_rxactive_i,
   input  logic               fe_rxerror_i,
   input  pw_pkg::pat_count_t pat_bytes_i,
   output pw_pkg::pattern_t   window_o,
   output logic               window_ready_o
);

   logic               rxactive_q;
   logic               pkt_start;   // first cycle of a packet
   pw_pkg::pat_count_t byte_cnt;
   pw_pkg::pat_count_t cnt_cur;
   logic               spoiled;
   logic               spoil_next;
   logic               take_byte;

   assign pkt_start  = fe_rxactive_i & ~rxactive_q;
   assign cnt_cur    = pkt_start ? '0 : byte_cnt;  // restart on a new packet
   assign spoil_next = (pkt_start ? 1'b0 : spoiled) | (fe_rxactive_i & fe_rxerror_i);

   // stop collecting once the window is full
   assign take_byte  = fe_rxactive_i & fe_rxvalid_i & (cnt_cur < pat_bytes_i);

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         rxactive_q     <= 1'b0;
         byte_cnt       <= '0;
         spoiled        <= 1'b0;
         window_ready_o <= 1'b0;
      end else begin
         rxactive_q     <= fe_rxactive_i;
         spoiled        <= spoil_next;
         byte_cnt       <= take_byte ? cnt_cur + 4'd1 : cnt_cur;
         // last pattern byte of a clean packet
         window_ready_o <= take_byte && (cnt_cur + 4'd1 == pat_bytes_i) && !spoil_next;
      end
   end

   // window bytes themselves
   always_ff @(posedge fe_clk) begin
      if (take_byte)
         window_o[cnt_cur] <= fe_data_i;
   end

endmodule

// File: rtl/pattern_matcher.sv
`timescale 1ns/1ps

module pattern_matcher (
   input  logic               fe_clk,
   input  logic               rst_n_i,
   input  pw_pkg::pattern_t   window_i,
   input  logic               window_ready_i,
   input  pw_pkg::pattern_t   pattern_i,
   input  pw_pkg::pattern_t   mask_i,
   input  pw_pkg::pat_count_t pat_bytes_i,
   input  logic               armed_i,
   output logic               match_o
);

   logic [pw_pkg::PATTERN_BYTES-1:0] byte_ok;
   logic                             all_ok;

   ////////////////////
   // per byte compare
   ////////////////////
   // only mask bits set to one take part in the compare,
   // and lanes beyond the byte count are don't care
   always_comb begin
      for (int i = 0; i < pw_pkg::PATTERN_BYTES; i++) begin
         if (i >= pat_bytes_i)
            byte_ok[i] = 1'b1;
         else
            byte_ok[i] = ((window_i[i] ^ pattern_i[i]) & mask_i[i]) == 8'h00;
      end
   end

   assign all_ok = &byte_ok;

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         match_o <= 1'b0;
      end else begin
         // one cycle pulse, only while armed
         match_o <= window_ready_i & armed_i & all_ok & (pat_bytes_i != '0);
      end
   end

endmodule

// File: rtl/trigger_gen.sv
`timescale 1ns/1ps

module trigger_gen (
   input  logic                fe_clk,
   input  logic                rst_n_i,
   input  logic                match_i,
   input  pw_pkg::trig_delay_t delay_i,
   input  pw_pkg::trig_width_t width_i,
   output logic                trig_o,
   output logic                busy_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DELAY,
      ST_PULSE
   } state_t;

   state_t              state_q;
   pw_pkg::trig_delay_t dly_cnt;
   pw_pkg::trig_width_t wid_cnt;  // cycles left after the current one

   ////////////////////
   // delay / pulse fsm
   ////////////////////
   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         dly_cnt <= '0;
         wid_cnt <= '0;
         trig_o  <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (match_i) begin  // matches while busy are dropped
                  dly_cnt <= delay_i;
                  state_q <= ST_DELAY;
               end
            end
            ST_DELAY: begin
               if (dly_cnt == '0) begin
                  if (width_i != '0) begin
                     wid_cnt <= width_i - 1'b1;
                     trig_o  <= 1'b1;
                     state_q <= ST_PULSE;
                  end else begin
                     state_q <= ST_IDLE;  // zero width, no pulse
                  end
               end else begin
                  dly_cnt <= dly_cnt - 1'b1;
               end
            end
            ST_PULSE: begin
               if (wid_cnt == '0) begin
                  trig_o  <= 1'b0;
                  state_q <= ST_IDLE;
               end else begin
                  wid_cnt <= wid_cnt - 1'b1;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   assign busy_o = (state_q != ST_IDLE);

endmodule

// File: rtl/pw_top.sv
`timescale 1ns/1ps

module pw_top (
   input  logic              fe_clk,
   input  logic              rst_n_i,
   // host register bus
   input  pw_pkg::reg_addr_t reg_addr_i,
   input  pw_pkg::reg_data_t reg_wdata_i,
   input  logic              reg_wr_i,
   input  logic              reg_rd_i,
   output pw_pkg::reg_data_t reg_rdata_o,
   // usb phy receive side
   input  pw_pkg::reg_data_t fe_data_i,
   input  logic              fe_rxvalid_i,
   input  logic              fe_rxactive_i,
   input  logic              fe_rxerror_i,
   output logic [1:0]        fe_xcvrsel_o,
   output logic              fe_termsel_o,
   // trigger and leds
   output logic              cw_trig_o,
   output logic              mcx_trig_o,
   output logic              led_trig_o,
   output logic              led_cap_o
);

   logic                armed;
   logic                match;
   logic                trig_busy;
   logic                window_ready;
   pw_pkg::usb_speed_t  speed;
   pw_pkg::pat_count_t  pat_bytes;
   pw_pkg::pattern_t    pattern;
   pw_pkg::pattern_t    mask;
   pw_pkg::pattern_t    window;
   pw_pkg::trig_delay_t delay;
   pw_pkg::trig_width_t width;

   pw_reg_file u_reg_file (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .reg_addr_i     (reg_addr_i),
      .reg_wdata_i    (reg_wdata_i),
      .reg_wr_i       (reg_wr_i),
      .reg_rd_i       (reg_rd_i),
      .reg_rdata_o    (reg_rdata_o),
      .match_i        (match),
      .trig_busy_i    (trig_busy),
      .armed_o        (armed),
      .speed_o        (speed),
      .pat_bytes_o    (pat_bytes),
      .pattern_o      (pattern),
      .mask_o         (mask),
      .delay_o        (delay),
      .width_o        (width)
   );

   rx_byte_window u_rx_window (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .fe_data_i      (fe_data_i),
      .fe_rxvalid_i   (fe_rxvalid_i),
      .fe_rxactive_i  (fe_rxactive_i),
      .fe_rxerror_i   (fe_rxerror_i),
      .pat_bytes_i    (pat_bytes),
      .window_o       (window),
      .window_ready_o (window_ready)
   );

   pattern_matcher u_matcher (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .window_i       (window),
      .window_ready_i (window_ready),
      .pattern_i      (pattern),
      .mask_i         (mask),
      .pat_bytes_i    (pat_bytes),
      .armed_i        (armed),
      .match_o        (match)
   );

   trigger_gen u_trigger (
      .fe_clk   (fe_clk),
      .rst_n_i  (rst_n_i),
      .match_i  (match),
      .delay_i  (delay),
      .width_i  (width),
      .trig_o   (cw_trig_o),
      .busy_o   (trig_busy)
   );

   ////////////////////
   // phy mode pins
   ////////////////////
   always_comb begin
      case (speed)
         pw_pkg::SPEED_LS: begin
            fe_xcvrsel_o = 2'b10;
            fe_termsel_o = 1'b1;
         end
         pw_pkg::SPEED_HS: begin
            fe_xcvrsel_o = 2'b00;
            fe_termsel_o = 1'b0;
         end
         default: begin  // auto falls back to full speed
            fe_xcvrsel_o = 2'b01;
            fe_termsel_o = 1'b1;
         end
      endcase
   end

   assign mcx_trig_o = cw_trig_o;
   assign led_trig_o = trig_busy;
   assign led_cap_o  = armed;

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;  // 40 ns period
   end

   // reset low for 8 rising edges
   initial begin
      rst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule

// File: testbench/tb_pw_top.sv
`timescale 1ns/1ps

module tb_pw_top;

   typedef struct packed {
      pw_pkg::usb_speed_t  speed;
      pw_pkg::pattern_t    pattern;
      pw_pkg::pattern_t    mask;
      pw_pkg::pat_count_t  n_bytes;
      pw_pkg::trig_delay_t delay;
      pw_pkg::trig_width_t width;
      logic                arm;
      int                  pkt_len;
      int                  err_pos;    // -1 for a clean packet
      int                  flip_byte;  // -1 when no bit is flipped
      logic [7:0]          flip_xor;
      logic                expect_trig;
   } row_t;

   logic              fe_clk;
   logic              rst_n;
   pw_pkg::reg_addr_t reg_addr;
   pw_pkg::reg_data_t reg_wdata;
   logic              reg_wr;
   logic              reg_rd;
   pw_pkg::reg_data_t reg_rdata;
   pw_pkg::reg_data_t fe_data;
   logic              fe_rxvalid;
   logic              fe_rxactive;
   logic              fe_rxerror;
   logic [1:0]        xcvrsel;
   logic              termsel;
   logic              cw_trig;
   logic              mcx_trig;
   logic              led_trig;
   logic              led_cap;

   integer seed = 67;
   int     cyc = 0;
   int     errors = 0;
   int     n_pass = 0;
   int     n_fail = 0;
   int     e_edge;      // edge that takes the last pattern byte
   int     rise_cyc;
   int     high_cnt;
   logic   trig_q = 1'b0;
   logic   trig_seen, pulse_done, busy_seen, mcx_bad;

   ////////////////////
   // case table
   ////////////////////
   // speed, pattern, mask, bytes, delay, width, arm, len, err, flip byte, flip xor, trig
   row_t rows [9] = '{
      '{pw_pkg::SPEED_AUTO, 64'hA5C31E69, 64'hFFFFFFFF, 4, 5, 3, 1, 6, -1, -1, 8'h00, 1},
      '{pw_pkg::SPEED_HS, 64'hA5C31E69, 64'hFFFFFFFF, 4, 5, 3, 0, 6, -1, -1, 8'h00, 0},
      '{pw_pkg::SPEED_LS, 64'h00773C80, 64'h00F00FF0, 3, 0, 1, 1, 5, -1, -1, 8'h00, 1},
      '{pw_pkg::SPEED_FS, 64'h00773C80, 64'h00F00FF0, 3, 4, 2, 1, 5, -1, 1, 8'h04, 0},
      '{pw_pkg::SPEED_FS, 64'h4B2D96E1, 64'hFFFFFFFF, 4, 1, 2, 0, 3, -1, -1, 8'h00, 0},
      '{pw_pkg::SPEED_FS, 64'h4B2D96E1, 64'hFFFFFFFF, 4, 1, 2, 0, 6, 1, -1, 8'h00, 0},
      '{pw_pkg::SPEED_AUTO, 64'h4B2D96E1, 64'hFFFFFFFF, 4, 300, 258, 0, 6, -1, -1, 8'h00, 1},
      '{pw_pkg::SPEED_HS, 64'h4B2D96E1, 64'hFFFFFFFF, 0, 2, 2, 1, 4, -1, -1, 8'h00, 0},
      '{pw_pkg::SPEED_LS, 64'h0123456789ABCDEF, '1, 8, 2, 2, 0, 8, -1, -1, 8'h00, 1}
   };
   string names [9] = '{"auto_match", "hs_not_armed", "ls_masked_off_bits",
                        "fs_masked_on_diff", "short_packet", "rx_error",
                        "match_after_error", "zero_count", "full_window"};

   tb_clock_gen u_clk (.clk_o(fe_clk), .rst_n_o(rst_n));

   pw_top UUT (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n),
      .reg_addr_i    (reg_addr),
      .reg_wdata_i   (reg_wdata),
      .reg_wr_i      (reg_wr),
      .reg_rd_i      (reg_rd),
      .reg_rdata_o   (reg_rdata),
      .fe_data_i     (fe_data),
      .fe_rxvalid_i  (fe_rxvalid),
      .fe_rxactive_i (fe_rxactive),
      .fe_rxerror_i  (fe_rxerror),
      .fe_xcvrsel_o  (xcvrsel),
      .fe_termsel_o  (termsel),
      .cw_trig_o     (cw_trig),
      .mcx_trig_o    (mcx_trig),
      .led_trig_o    (led_trig),
      .led_cap_o     (led_cap)
   );

   always @(posedge fe_clk) cyc <= cyc + 1;

   // trigger observer on the falling edge
   always @(negedge fe_clk) begin
      if (cw_trig !== mcx_trig) mcx_bad = 1'b1;
      if (led_trig === 1'b1) busy_seen = 1'b1;
      if (cw_trig === 1'b1 && !trig_q) begin
         rise_cyc  = cyc;  // edge count when the pulse rose
         trig_seen = 1'b1;
      end
      if (cw_trig === 1'b1) high_cnt++;
      if (cw_trig !== 1'b1 && trig_q) pulse_done = 1'b1;
      trig_q = (cw_trig === 1'b1);
   end

   ////////////////////
   // compare tasks
   ////////////////////
   task automatic report_mismatch(input string name, input logic [63:0] exp, act);
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
      errors++;
   endtask

   task automatic check_data(input string name, input pw_pkg::reg_data_t exp, act);
      if (exp !== act) report_mismatch(name, exp, act);
   endtask

   task automatic check_speed_pins(input string name, input logic [1:0] exp_x,
                                   input logic exp_t, input logic [1:0] act_x,
                                   input logic act_t);
      if ({exp_x, exp_t} !== {act_x, act_t}) report_mismatch(name, {exp_x, exp_t}, {act_x, act_t});
   endtask

   task automatic check_delay(input string name, input pw_pkg::trig_delay_t exp, act);
      if (exp !== act) report_mismatch(name, exp, act);
   endtask

   task automatic check_width(input string name, input pw_pkg::trig_width_t exp, act);
      if (exp !== act) report_mismatch(name, exp, act);
   endtask

   task automatic check_flag(input string name, input logic exp, act);
      if (exp !== act) report_mismatch(name, exp, act);
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("test %s ok", name);
         n_pass++;
      end else begin
         $display("test %s failed", name);
         n_fail++;
      end
   endtask

   // {xcvrsel, termsel} for a speed code
   function automatic logic [2:0] phy_mode(input pw_pkg::usb_speed_t s);
      case (s)
         pw_pkg::SPEED_LS: return 3'b101;
         pw_pkg::SPEED_HS: return 3'b000;
         default:          return 3'b011;
      endcase
   endfunction

   ////////////////////
   // bus and packet drivers
   ////////////////////
   task automatic write_reg(input pw_pkg::reg_addr_t a, input pw_pkg::reg_data_t d);
      @(posedge fe_clk);
      #2;
      reg_addr  = a;
      reg_wdata = d;
      reg_wr    = 1'b1;
      @(posedge fe_clk);
      #2 reg_wr = 1'b0;
   endtask

   task automatic read_reg(input pw_pkg::reg_addr_t a, output pw_pkg::reg_data_t d);
      @(posedge fe_clk);
      #2;
      reg_addr = a;
      reg_rd   = 1'b1;
      @(posedge fe_clk);
      #2 reg_rd = 1'b0;
      @(posedge fe_clk);
      #2 d = reg_rdata;  // held until the next read
   endtask

   task automatic configure(input row_t r);
      for (int i = 0; i < pw_pkg::PATTERN_BYTES; i++) begin
         write_reg(pw_pkg::reg_addr_t'(pw_pkg::ADDR_PATTERN0 + i), r.pattern[i]);
         write_reg(pw_pkg::reg_addr_t'(pw_pkg::ADDR_MASK0 + i), r.mask[i]);
      end
      write_reg(pw_pkg::ADDR_SPEED, {6'b0, r.speed});
      write_reg(pw_pkg::ADDR_PAT_BYTES, {4'b0, r.n_bytes});
      for (int i = 0; i < 3; i++) begin
         write_reg(pw_pkg::reg_addr_t'(pw_pkg::ADDR_DELAY0 + i), 8'(r.delay >> (8 * i)));
         write_reg(pw_pkg::reg_addr_t'(pw_pkg::ADDR_WIDTH0 + i), 8'(r.width >> (8 * i)));
      end
   endtask

   // bytes_ok tells whether the masked bits of the window equal the pattern
   task automatic send_packet(input row_t r, output logic bytes_ok);
      logic [7:0] b;
      bytes_ok = 1'b1;
      @(posedge fe_clk);
      #2 fe_rxactive = 1'b1;
      for (int i = 0; i < r.pkt_len; i++) begin
         b = 8'($random(seed));
         if (i < r.n_bytes) begin
            b = (r.pattern[i] & r.mask[i]) | (b & ~r.mask[i]);  // random masked-off bits
            if (i == r.flip_byte) b = b ^ r.flip_xor;
            if ((b & r.mask[i]) != (r.pattern[i] & r.mask[i])) bytes_ok = 1'b0;
         end
         @(posedge fe_clk);
         #2;
         fe_data    = b;
         fe_rxvalid = 1'b1;
         fe_rxerror = (i == r.err_pos);
         if (i == r.n_bytes - 1) e_edge = cyc + 1;
      end
      @(posedge fe_clk);
      #2;
      fe_rxactive = 1'b0;
      fe_rxvalid  = 1'b0;
      fe_rxerror  = 1'b0;
      @(posedge fe_clk);
   endtask

   task automatic wait_trigger(input row_t r, input logic expected);
      int limit;
      limit = r.delay + r.width + 20;
      for (int i = 0; i < limit && !(expected ? pulse_done : trig_seen); i++)
         @(posedge fe_clk);
      if (expected && !pulse_done) begin
         $display("trigger pulse did not finish within %0d cycles", limit);
         errors++;
      end
   endtask

   initial begin
      row_t              r;
      pw_pkg::reg_data_t rd;
      int                start_errors;
      logic              bytes_ok, exp_match, exp_trig;
      logic              armed_model;
      logic [2:0]        exp_mode;
      reg_addr    = '0;
      reg_wdata   = '0;
      reg_wr      = 1'b0;
      reg_rd      = 1'b0;
      fe_data     = '0;
      fe_rxvalid  = 1'b0;
      fe_rxactive = 1'b0;
      fe_rxerror  = 1'b0;
      armed_model = 1'b0;
      for (int i = 0; i < 20 && rst_n !== 1'b1; i++)
         @(posedge fe_clk);
      if (rst_n !== 1'b1) begin
         $display("reset was never released");
         errors++;
      end

      start_errors = errors;
      check_data("reset read data", 8'h00, reg_rdata);
      check_flag("reset mcx trigger", 1'b0, mcx_trig);
      check_flag("reset busy led", 1'b0, led_trig);
      read_reg(pw_pkg::ADDR_ARM, rd);
      check_data("reset arm", 8'h00, rd);
      check_speed_pins("reset phy", 2'b01, 1'b1, xcvrsel, termsel);
      check_flag("reset trigger", 1'b0, cw_trig);
      check_flag("reset armed led", 1'b0, led_cap);
      report_test("reset_state", start_errors);

      // pattern and mask lanes sit at 0x10 .. 0x1f
      start_errors = errors;
      for (int i = 0; i < 16; i++)
         write_reg(pw_pkg::reg_addr_t'(pw_pkg::ADDR_PATTERN0 + i), 8'(i * 37 + 5));
      write_reg(pw_pkg::ADDR_DELAY0, 8'h12);
      write_reg(pw_pkg::ADDR_DELAY2, 8'hFF);
      write_reg(pw_pkg::ADDR_WIDTH1, 8'h78);
      write_reg(pw_pkg::ADDR_WIDTH2, 8'hFF);
      write_reg(pw_pkg::ADDR_PAT_BYTES, 8'd12);
      for (int i = 0; i < 16; i++) begin
         read_reg(pw_pkg::reg_addr_t'(pw_pkg::ADDR_PATTERN0 + i), rd);
         check_data("pattern/mask byte", 8'(i * 37 + 5), rd);
      end
      read_reg(pw_pkg::ADDR_DELAY0, rd);
      check_data("delay byte 0", 8'h12, rd);
      read_reg(pw_pkg::ADDR_DELAY2, rd);
      check_data("delay top byte", 8'h0F, rd);
      read_reg(pw_pkg::ADDR_WIDTH1, rd);
      check_data("width byte 1", 8'h78, rd);
      read_reg(pw_pkg::ADDR_WIDTH2, rd);
      check_data("width top byte", 8'h01, rd);
      read_reg(pw_pkg::ADDR_PAT_BYTES, rd);
      check_data("pattern byte count", 8'h08, rd);
      read_reg(8'h09, rd);
      check_data("unmapped address", 8'h00, rd);
      report_test("reg_readback", start_errors);

      for (int k = 0; k < 9; k++) begin
         r = rows[k];
         start_errors = errors;
         configure(r);
         exp_mode = phy_mode(r.speed);
         check_speed_pins({names[k], " phy"}, exp_mode[2:1], exp_mode[0], xcvrsel, termsel);
         if (r.arm) begin
            write_reg(pw_pkg::ADDR_ARM, 8'h01);
            armed_model = 1'b1;
            check_flag({names[k], " armed led"}, 1'b1, led_cap);
         end
         trig_seen  = 1'b0;
         pulse_done = 1'b0;
         busy_seen  = 1'b0;
         mcx_bad    = 1'b0;
         high_cnt   = 0;
         send_packet(r, bytes_ok);
         // masked match rule on a clean window
         exp_match = armed_model && r.n_bytes != 0 && r.pkt_len >= r.n_bytes &&
                     (r.err_pos < 0 || r.err_pos >= r.n_bytes) && bytes_ok;
         exp_trig  = exp_match && r.width != 0;
         check_flag({names[k], " table row"}, r.expect_trig, exp_trig);
         wait_trigger(r, exp_trig);
         check_flag({names[k], " trigger"}, exp_trig, trig_seen);
         check_flag({names[k], " mcx copy"}, 1'b0, mcx_bad);
         if (exp_trig) begin
            check_delay({names[k], " delay"}, r.delay,
                        pw_pkg::trig_delay_t'(rise_cyc - e_edge - 3));
            check_width({names[k], " width"}, r.width, pw_pkg::trig_width_t'(high_cnt));
            check_flag({names[k], " busy led"}, 1'b1, busy_seen);
         end
         if (exp_match) armed_model = 1'b0;  // a match disarms
         read_reg(pw_pkg::ADDR_ARM, rd);
         check_data({names[k], " arm status"}, {7'b0, armed_model}, rd);
         check_flag({names[k], " armed led after"}, armed_model, led_cap);
         check_flag({names[k], " busy led after"}, 1'b0, led_trig);
         report_test(names[k], start_errors);
      end

      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (errors == 0 && n_fail == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: vlog.f
rtl/pw_pkg.sv
rtl/pw_reg_file.sv
rtl/rx_byte_window.sv
rtl/pattern_matcher.sv
rtl/trigger_gen.sv
rtl/pw_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pw_top.sv

// File: Bender.yml
package:
  name: usb_trigger_core

sources:
  - rtl/pw_pkg.sv
  - rtl/pw_reg_file.sv
  - rtl/rx_byte_window.sv
  - rtl/pattern_matcher.sv
  - rtl/trigger_gen.sv
  - rtl/pw_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_pw_top.sv
